/* project.f */
renamePkg.sv
FreeTagCounter.sv
TagBuffer.sv
RenameTable.sv
Rename.sv
RenameTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rename testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module RenameTb -Mdir obj_dir -o simRename
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simRename)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "PASS: all tests" <<< "$simOut"; then
    exit 0
fi
exit 1

/* RenameTb.sv */
`default_nettype none
`timescale 1ns/1ps

module RenameTb;
    import renamePkg::*;

    localparam int NUM_UOPS = 4;
    localparam tagT NO_TAG = tagT'(64);

    // Test lengths in cycles with the exhaustion test at its upper bound
    localparam int T_RESET = 1;
    localparam int T_ALLOC = 12;
    localparam int T_BYPASS = 40;
    localparam int T_COMMIT = 30;
    localparam int T_MISPR = 80;
    localparam int T_EXHAUST = 62;
    localparam int CYCLE_LIMIT = 8 + 1 + T_RESET + T_ALLOC + T_BYPASS + T_COMMIT
                               + T_MISPR + T_EXHAUST + 100;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      mispr = 1'b0;
    IssueLane  issue [NUM_UOPS-1:0] = '{default: '0};
    CommitLane commit [NUM_UOPS-1:0] = '{default: '0};
    IssueResp  resp [NUM_UOPS-1:0];

    // Next inputs that move onto the DUT at the rising edge
    logic      rstStage = 1'b1;
    logic      misprStage = 1'b0;
    IssueLane  issueStage [NUM_UOPS-1:0] = '{default: '0};
    CommitLane commitStage [NUM_UOPS-1:0] = '{default: '0};

    // Reference model of the free list and both maps
    logic [NUM_TAGS-1:0] mUsed;
    logic [NUM_TAGS-1:0] mComm;
    tagT                 mSpec [NUM_ARCH];
    tagT                 mCommMap [NUM_ARCH];
    // In-order micro-ops that are issued and not yet squashed
    archT                qArch [$];
    tagT                 qTag [$];

    logic [15:0] lfsr = 16'd68;
    string       curTest;
    int          testErrs = 0;
    int          totalErrs = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          cycleCount = 0;

    Rename #(
        .NUM_UOPS (NUM_UOPS)
    ) i_dut (
        .clk    (clk),
        .rst    (rst),
        .mispr  (mispr),
        .issue  (issue),
        .commit (commit),
        .resp   (resp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        rst    <= rstStage;
        mispr  <= misprStage;
        issue  <= issueStage;
        commit <= commitStage;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, a test did not finish", cycleCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ************************************************************************
    // Helpers
    // ************************************************************************

    // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit taken
    function automatic int unsigned randBits(input int n);
        int unsigned val;
        logic        fb;
        val = 0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic int modelFree();
        return $countones(~mUsed);
    endfunction

    task automatic noteError();
        testErrs++;
        totalErrs++;
    endtask

    task automatic checkTag(input string what, input int lane, input tagT exp, input tagT act);
        if (act !== exp) begin
            $display("ERR %s: %s lane %0d expected %0d actual %0d",
                     curTest, what, lane, exp, act);
            noteError();
        end
    endtask

    task automatic checkValid(input string what, input int lane, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("ERR %s: %s lane %0d expected %0b actual %0b",
                     curTest, what, lane, exp, act);
            noteError();
        end
    endtask

    task automatic startTest(input string name);
        curTest  = name;
        testErrs = 0;
    endtask

    task automatic endTest();
        testsRun++;
        if (testErrs == 0) begin
            $display("test %s: ok", curTest);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", curTest, testErrs);
        end
    endtask

    // ************************************************************************
    // One cycle of stimulus, prediction, check and model update
    // ************************************************************************

    // issueMode 0 none, 1 random lanes, 2 every offered lane
    // commitMode 0 none, 1 random count, 2 four oldest
    task automatic doCycle(input int issueMode, input int commitMode, input bit misprOn,
                           input int archBits);
        tagT                 expTag [NUM_UOPS];
        logic                expValid [NUM_UOPS];
        tagT                 expPrev [NUM_UOPS];
        IssueLane            iss [NUM_UOPS-1:0];
        CommitLane           com [NUM_UOPS-1:0];
        logic [NUM_TAGS-1:0] avail;
        logic                found;
        logic                mp;
        int unsigned         pick;
        int                  nFree;
        int                  nCommit;
        tagT                 prevT;
        avail = ~mUsed;
        nFree = modelFree();

        // Offers walk the free set from the top
        for (int i = 0; i < NUM_UOPS; i++) begin
            found     = 1'b0;
            expTag[i] = NO_TAG;
            for (int t = NUM_TAGS - 1; t >= 0; t--) begin
                if (!found && avail[t]) begin
                    expTag[i] = tagT'(t);
                    avail[t]  = 1'b0;
                    found     = 1'b1;
                end
            end
            expValid[i] = nFree > i;
        end

        for (int i = 0; i < NUM_UOPS; i++) begin
            pick            = randBits(1);
            iss[i].archDst  = archT'(randBits(archBits));
            iss[i].valid    = expValid[i] && (issueMode == 2 || (issueMode == 1 && pick == 1));
        end

        // Speculative mapping overridden by a lower lane of the same group
        for (int i = 0; i < NUM_UOPS; i++) begin
            expPrev[i] = mSpec[iss[i].archDst];
            for (int j = 0; j < i; j++) begin
                if (iss[j].valid && iss[j].archDst == iss[i].archDst) begin
                    expPrev[i] = expTag[j];
                end
            end
        end

        nCommit = 0;
        if (commitMode == 2) begin
            nCommit = NUM_UOPS;
        end else if (commitMode == 1) begin
            nCommit = int'(randBits(3) % 5);
        end
        if (nCommit > qArch.size()) begin
            nCommit = qArch.size();
        end
        for (int i = 0; i < NUM_UOPS; i++) begin
            com[i] = '0;
            if (i < nCommit) begin
                com[i].valid   = 1'b1;
                com[i].archDst = qArch[i];
                com[i].tagDst  = qTag[i];
            end
        end
        mp = misprOn && (randBits(3) == 0);

        issueStage  = iss;
        commitStage = com;
        misprStage  = mp;
        @(posedge clk);
        @(negedge clk);

        for (int i = 0; i < NUM_UOPS; i++) begin
            checkValid("offer valid", i, expValid[i], resp[i].tagValid);
            if (expValid[i]) begin
                checkTag("offered tag", i, expTag[i], resp[i].tag);
            end
            checkTag("previous tag", i, expPrev[i], resp[i].prevTag);
        end

        // Model update with the mispredict clear first and commits after it
        if (mp) begin
            mUsed = mUsed & mComm;
        end else begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                if (iss[i].valid) begin
                    mUsed[expTag[i][TAG_W-2:0]] = 1'b1;
                    mSpec[iss[i].archDst]       = expTag[i];
                    qArch.push_back(iss[i].archDst);
                    qTag.push_back(expTag[i]);
                end
            end
        end
        for (int i = 0; i < nCommit; i++) begin
            prevT = mCommMap[com[i].archDst];
            if (!prevT[TAG_W-1]) begin
                mUsed[prevT[TAG_W-2:0]] = 1'b0;
                mComm[prevT[TAG_W-2:0]] = 1'b0;
            end
            mUsed[com[i].tagDst[TAG_W-2:0]] = 1'b1;
            mComm[com[i].tagDst[TAG_W-2:0]] = 1'b1;
            mCommMap[com[i].archDst]        = com[i].tagDst;
            void'(qArch.pop_front());
            void'(qTag.pop_front());
        end
        if (mp) begin
            mSpec = mCommMap;
            qArch.delete();
            qTag.delete();
        end
    endtask

    task automatic runCycles(input string name, input int n, input int issueMode,
                             input int commitMode, input bit misprOn, input int archBits);
        startTest(name);
        repeat (n) doCycle(issueMode, commitMode, misprOn, archBits);
        endTest();
    endtask

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin
        int n;
        mUsed = '0;
        mComm = '0;
        for (int a = 0; a < NUM_ARCH; a++) begin
            mSpec[a]    = NO_TAG;
            mCommMap[a] = NO_TAG;
        end
        repeat (7) @(posedge clk);
        @(negedge clk);
        rstStage = 1'b0;
        @(posedge clk);
        @(negedge clk);

        startTest("reset");
        doCycle(0, 0, 1'b0, 5);
        for (int i = 0; i < NUM_UOPS; i++) begin
            checkTag("tag after reset", i, tagT'(63 - i), resp[i].tag);
            checkValid("valid after reset", i, 1'b1, resp[i].tagValid);
            checkTag("previous after reset", i, NO_TAG, resp[i].prevTag);
        end
        endTest();

        runCycles("allocation", T_ALLOC, 1, 0, 1'b0, 5);
        // Few registers so that lanes of one group often collide
        runCycles("bypass", T_BYPASS, 1, 1, 1'b0, 2);
        runCycles("commit release", T_COMMIT, 1, 2, 1'b0, 2);
        runCycles("mispredict", T_MISPR, 1, 1, 1'b1, 3);

        startTest("exhaustion");
        n = 0;
        while (modelFree() >= NUM_UOPS && n < 30) begin
            doCycle(2, 0, 1'b0, 5);
            n++;
        end
        if (modelFree() >= NUM_UOPS) begin
            $display("%s: issuing did not use up the free tags", curTest);
            noteError();
        end
        doCycle(0, 0, 1'b0, 5);
        checkValid("upper lane when exhausted", NUM_UOPS - 1, 1'b0,
                   resp[NUM_UOPS-1].tagValid);
        n = 0;
        while (modelFree() < NUM_UOPS && n < 30) begin
            doCycle(0, 2, 1'b0, 5);
            n++;
        end
        if (modelFree() < NUM_UOPS) begin
            $display("%s: commits did not release enough tags", curTest);
            noteError();
        end
        doCycle(0, 0, 1'b0, 5);
        checkValid("upper lane after commits", NUM_UOPS - 1, 1'b1,
                   resp[NUM_UOPS-1].tagValid);
        endTest();

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, totalErrs);
        if (totalErrs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* Rename.sv */
`default_nettype none
`timescale 1ns/1ps

module Rename #(
    parameter int NUM_UOPS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mispr,
    input  renamePkg::IssueLane  issue  [NUM_UOPS-1:0],
    input  renamePkg::CommitLane commit [NUM_UOPS-1:0],
    output renamePkg::IssueResp  resp   [NUM_UOPS-1:0]
);
    import renamePkg::*;

    tagT  offerTags      [NUM_UOPS-1:0];
    logic offerValid     [NUM_UOPS-1:0];
    tagT  prevTags       [NUM_UOPS-1:0];
    tagT  commitPrevTags [NUM_UOPS-1:0];

    RenameTable #(
        .NUM_UOPS (NUM_UOPS)
    ) i_renameTable (
        .clk            (clk),
        .rst            (rst),
        .mispr          (mispr),
        .issue          (issue),
        .newTags        (offerTags),
        .commit         (commit),
        .prevTags       (prevTags),
        .commitPrevTags (commitPrevTags)
    );

    TagBuffer #(
        .NUM_UOPS (NUM_UOPS)
    ) i_tagBuffer (
        .clk            (clk),
        .rst            (rst),
        .mispr          (mispr),
        .issue          (issue),
        .commit         (commit),
        .commitPrevTags (commitPrevTags),
        .offerTags      (offerTags),
        .offerValid     (offerValid)
    );

    // Per-lane response
    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            resp[i].tag      = offerTags[i];
            resp[i].tagValid = offerValid[i];
            resp[i].prevTag  = prevTags[i];
        end
    end

endmodule

`default_nettype wire

/* RenameTable.sv */
`default_nettype none
`timescale 1ns/1ps

module RenameTable #(
    parameter int NUM_UOPS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mispr,
    input  renamePkg::IssueLane  issue          [NUM_UOPS-1:0],
    input  renamePkg::tagT       newTags        [NUM_UOPS-1:0],
    input  renamePkg::CommitLane commit         [NUM_UOPS-1:0],
    output renamePkg::tagT       prevTags       [NUM_UOPS-1:0],
    output renamePkg::tagT       commitPrevTags [NUM_UOPS-1:0]
);
    import renamePkg::*;

    // Mapping held by every register after reset
    localparam tagT NO_TAG = {1'b1, {(TAG_W-1){1'b0}}};

    // Speculative and committed maps
    tagT specMap     [NUM_ARCH-1:0];
    tagT commMap     [NUM_ARCH-1:0];
    tagT specMapNext [NUM_ARCH-1:0];
    tagT commMapNext [NUM_ARCH-1:0];

    // ************************************************************************
    // Lookup with in-group bypass
    // ************************************************************************

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            prevTags[i] = specMap[issue[i].archDst];
            // Highest lower lane writing the same register wins
            for (int j = 0; j < i; j++) begin
                if (issue[j].valid && issue[j].archDst == issue[i].archDst) begin
                    prevTags[i] = newTags[j];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            commitPrevTags[i] = commMap[commit[i].archDst];
            for (int j = 0; j < i; j++) begin
                if (commit[j].valid && commit[j].archDst == commit[i].archDst) begin
                    commitPrevTags[i] = commit[j].tagDst;
                end
            end
        end
    end

    // ************************************************************************
    // Map update
    // ************************************************************************

    always_comb begin
        commMapNext = commMap;
        for (int i = 0; i < NUM_UOPS; i++) begin
            if (commit[i].valid) begin
                commMapNext[commit[i].archDst] = commit[i].tagDst;
            end
        end

        if (mispr) begin
            // Restore from the committed map including this cycle's commits
            specMapNext = commMapNext;
        end else begin
            specMapNext = specMap;
            // Ascending order lets the highest lane win
            for (int i = 0; i < NUM_UOPS; i++) begin
                if (issue[i].valid) begin
                    specMapNext[issue[i].archDst] = newTags[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                specMap[i] <= NO_TAG;
                commMap[i] <= NO_TAG;
            end
        end else begin
            specMap <= specMapNext;
            commMap <= commMapNext;
        end
    end

endmodule

`default_nettype wire

/* TagBuffer.sv */
`default_nettype none
`timescale 1ns/1ps

module TagBuffer #(
    parameter int NUM_UOPS = 4,
    localparam int CNT_W = $clog2(NUM_UOPS + 1)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mispr,
    input  renamePkg::IssueLane  issue          [NUM_UOPS-1:0],
    input  renamePkg::CommitLane commit         [NUM_UOPS-1:0],
    input  renamePkg::tagT       commitPrevTags [NUM_UOPS-1:0],
    output renamePkg::tagT       offerTags      [NUM_UOPS-1:0],
    output logic                 offerValid     [NUM_UOPS-1:0]
);
    import renamePkg::*;

    localparam int IDX_W = $clog2(NUM_TAGS);

    // Per-tag state
    logic [NUM_TAGS-1:0] used;
    logic [NUM_TAGS-1:0] committed;
    logic [NUM_TAGS-1:0] usedNext;
    logic [NUM_TAGS-1:0] committedNext;

    logic [CNT_W-1:0] freeCount;

    // ************************************************************************
    // Tag offer
    // ************************************************************************

    FreeTagCounter #(
        .NUM_UOPS (NUM_UOPS)
    ) i_freeTagCounter (
        .used      (used),
        .freeCount (freeCount)
    );

    // Lane i gets the (i+1)-th highest free tag
    always_comb begin
        logic [NUM_TAGS-1:0] avail;
        logic [IDX_W-1:0]    pick;
        logic                found;
        avail = ~used;
        for (int i = 0; i < NUM_UOPS; i++) begin
            pick  = '0;
            found = 1'b0;
            // Ascending scan where the last hit is the highest free tag
            for (int j = 0; j < NUM_TAGS; j++) begin
                if (avail[j]) begin
                    pick  = IDX_W'(j);
                    found = 1'b1;
                end
            end
            if (found) begin
                avail[pick]  = 1'b0;
                offerTags[i] = {1'b0, pick};
            end else begin
                offerTags[i] = {1'b1, {IDX_W{1'b0}}};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_UOPS; i++) begin
            offerValid[i] = freeCount > CNT_W'(i);
        end
    end

    // ************************************************************************
    // State update
    // ************************************************************************

    always_comb begin
        usedNext      = used;
        committedNext = committed;

        if (mispr) begin
            // Everything not yet committed goes back to the free list
            usedNext = used & committed;
        end else begin
            for (int i = 0; i < NUM_UOPS; i++) begin
                if (issue[i].valid && offerValid[i]) begin
                    usedNext[offerTags[i][IDX_W-1:0]] = 1'b1;
                end
            end
        end

        // Commits land after the mispredict clear and win over it
        for (int i = 0; i < NUM_UOPS; i++) begin
            if (commit[i].valid) begin
                // Release the mapping this commit replaces
                if (!commitPrevTags[i][TAG_W-1]) begin
                    usedNext[commitPrevTags[i][IDX_W-1:0]]      = 1'b0;
                    committedNext[commitPrevTags[i][IDX_W-1:0]] = 1'b0;
                end
                // Confirm the new one
                if (!commit[i].tagDst[TAG_W-1]) begin
                    usedNext[commit[i].tagDst[IDX_W-1:0]]      = 1'b1;
                    committedNext[commit[i].tagDst[IDX_W-1:0]] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            used      <= '0;
            committed <= '0;
        end else begin
            used      <= usedNext;
            committed <= committedNext;
        end
    end

endmodule

`default_nettype wire

/* FreeTagCounter.sv */
`default_nettype none
`timescale 1ns/1ps

module FreeTagCounter #(
    parameter int NUM_UOPS = 4,
    localparam int CNT_W = $clog2(NUM_UOPS + 1)
) (
    input  logic [renamePkg::NUM_TAGS-1:0] used,
    output logic [CNT_W-1:0]               freeCount
);
    import renamePkg::*;

    // Add two partial counts clamped to the lane count
    function automatic logic [2:0] satAdd(input logic [2:0] a, input logic [2:0] b);
        logic [3:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return (sum > 4'(NUM_UOPS)) ? 3'(NUM_UOPS) : sum[2:0];
    endfunction

    // Pairs and quads are counted exactly
    logic [1:0] stage0 [NUM_TAGS/2-1:0];
    logic [2:0] stage1 [NUM_TAGS/4-1:0];

    // Saturating levels
    logic [2:0] stage2 [NUM_TAGS/8-1:0];
    logic [2:0] stage3 [NUM_TAGS/16-1:0];
    logic [2:0] stage4 [NUM_TAGS/32-1:0];

    always_comb begin
        for (int i = 0; i < NUM_TAGS/2; i++) begin
            stage0[i] = {1'b0, ~used[2*i]} + {1'b0, ~used[2*i+1]};
        end
        for (int i = 0; i < NUM_TAGS/4; i++) begin
            stage1[i] = {1'b0, stage0[2*i]} + {1'b0, stage0[2*i+1]};
        end
        for (int i = 0; i < NUM_TAGS/8; i++) begin
            stage2[i] = satAdd(stage1[2*i], stage1[2*i+1]);
        end
        for (int i = 0; i < NUM_TAGS/16; i++) begin
            stage3[i] = satAdd(stage2[2*i], stage2[2*i+1]);
        end
        for (int i = 0; i < NUM_TAGS/32; i++) begin
            stage4[i] = satAdd(stage3[2*i], stage3[2*i+1]);
        end
        // Root of the tree
        freeCount = CNT_W'(satAdd(stage4[0], stage4[1]));
    end

endmodule

`default_nettype wire

/* renamePkg.sv */
`default_nettype none

package renamePkg;

    // ************************************************************************
    // Widths and sizes
    // ************************************************************************

    // Tag width including the top no-register flag
    parameter int TAG_W = 7;

    // Physical tags in the free list
    parameter int NUM_TAGS = 64;

    // Architectural registers in each map
    parameter int NUM_ARCH = 32;

    // ************************************************************************
    // Types
    // ************************************************************************

    // Bit 6 set means no physical register
    typedef logic [TAG_W-1:0] tagT;

    typedef logic [$clog2(NUM_ARCH)-1:0] archT;

    // One rename request lane
    typedef struct packed {
        logic valid;
        archT archDst;
    } IssueLane;

    // Offered tag, whether it may be used, and the mapping it replaces
    typedef struct packed {
        tagT  tag;
        logic tagValid;
        tagT  prevTag;
    } IssueResp;

    // One retiring micro-op
    typedef struct packed {
        logic valid;
        archT archDst;
        tagT  tagDst;
    } CommitLane;

endpackage

`default_nettype wire
